/* source/cpuPkg.sv */
package cpuPkg;

	typedef logic [31:0] dataT;
	typedef logic [4:0] regIndexT;

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		opR    = 6'b000000,
		opJ    = 6'b000010,
		opBne  = 6'b000101,
		opLi   = 6'b001001,
		opXori = 6'b001110,
		opLw   = 6'b100011,
		opSw   = 6'b101011
	} opcodeT;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		funcAdd = 6'b100000,
		funcSub = 6'b100010,
		funcSlt = 6'b101010
	} funcT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluSlt,
		aluXor,
		aluPassB
	} aluOpT;

	typedef struct packed {
		logic valid;
		dataT pcPlusOne;
		dataT instr;
	} fetchDecodeT;

	typedef struct packed {
		logic valid;
		opcodeT opcode;
		aluOpT aluOp;
		regIndexT rs;
		regIndexT rt;
		regIndexT dest;
		logic writesReg;
		dataT operandA;
		dataT operandB;
		dataT immediate;
		dataT branchTarget;
	} decodeExecuteT;

	typedef struct packed {
		logic valid;
		logic isLoad;
		logic isStore;
		logic writesReg;
		regIndexT dest;
		dataT result;
		dataT storeData;
	} executeMemoryT;

	// Valid only for writes to a nonzero register
	typedef struct packed {
		logic valid;
		regIndexT dest;
		dataT data;
	} regWriteT;

endpackage

/* source/fetchStage.sv */
module fetchStage #(
	parameter int instrAddrWidth = 10
) (
	input logic clk,
	input logic reset,
	input cpuPkg::dataT instr,
	output logic [instrAddrWidth-1:0] instrAddr,
	input logic branchTaken,
	input cpuPkg::dataT branchTarget,
	input logic jumpTaken,
	input cpuPkg::dataT jumpTarget,
	output cpuPkg::fetchDecodeT fetchDecode
);
	import cpuPkg::*;

	dataT pc;
	dataT nextPc;
	logic redirect;

	assign instrAddr = pc[instrAddrWidth-1:0];
	assign redirect = branchTaken || jumpTaken;

	// Branch from execute is older than a jump in decode
	always_comb begin
		if (branchTaken) begin
			nextPc = branchTarget;
		end else if (jumpTaken) begin
			nextPc = jumpTarget;
		end else begin
			nextPc = pc + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			fetchDecode.valid <= 1'b0;
		end else begin
			pc <= nextPc;
			// Word fetched on the wrong path is dropped
			fetchDecode.valid <= !redirect;
		end
		fetchDecode.pcPlusOne <= pc + 32'd1;
		fetchDecode.instr <= instr;
	end

endmodule

/* source/decodeStage.sv */
module decodeStage (
	input logic clk,
	input logic reset,
	input cpuPkg::fetchDecodeT fetchDecode,
	input cpuPkg::regWriteT regWrite,
	input logic branchTaken,
	output logic jumpTaken,
	output cpuPkg::dataT jumpTarget,
	output cpuPkg::decodeExecuteT decodeExecute
);
	import cpuPkg::*;

	dataT regFile [32];
	opcodeT opcode;
	funcT func;
	regIndexT rs;
	regIndexT rt;
	regIndexT rd;
	regIndexT dest;
	logic writesReg;
	aluOpT aluOp;
	dataT immediate;
	dataT readA;
	dataT readB;

	// Write-first read, register zero is hardwired
	function automatic dataT readReg(regIndexT idx, dataT stored, regWriteT wr);
		if (idx == '0) begin
			return '0;
		end
		if (wr.valid && wr.dest == idx) begin
			return wr.data;
		end
		return stored;
	endfunction

	always_ff @(posedge clk) begin
		if (regWrite.valid) begin
			regFile[regWrite.dest] <= regWrite.data;
		end
	end

	assign opcode = opcodeT'(fetchDecode.instr[31:26]);
	assign func = funcT'(fetchDecode.instr[5:0]);
	assign rs = fetchDecode.instr[25:21];
	assign rt = fetchDecode.instr[20:16];
	assign rd = fetchDecode.instr[15:11];
	assign immediate = {{16{fetchDecode.instr[15]}}, fetchDecode.instr[15:0]};

	assign readA = readReg(rs, regFile[rs], regWrite);
	assign readB = readReg(rt, regFile[rt], regWrite);

	assign jumpTaken = fetchDecode.valid && opcode == opJ;
	assign jumpTarget = {fetchDecode.pcPlusOne[31:26], fetchDecode.instr[25:0]};

	always_comb begin
		aluOp = aluAdd;
		dest = rt;
		writesReg = 1'b0;
		case (opcode)
			opR: begin
				dest = rd;
				writesReg = 1'b1;
				case (func)
					funcAdd: aluOp = aluAdd;
					funcSub: aluOp = aluSub;
					funcSlt: aluOp = aluSlt;
					default: writesReg = 1'b0;
				endcase
			end
			opXori: begin
				aluOp = aluXor;
				writesReg = 1'b1;
			end
			opLi: begin
				aluOp = aluPassB;
				writesReg = 1'b1;
			end
			opLw: writesReg = 1'b1;
			opBne: aluOp = aluSub;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			decodeExecute.valid <= 1'b0;
		end else begin
			// Younger than a taken branch in execute
			decodeExecute.valid <= fetchDecode.valid && !branchTaken;
		end
		decodeExecute.opcode <= opcode;
		decodeExecute.aluOp <= aluOp;
		decodeExecute.rs <= rs;
		decodeExecute.rt <= rt;
		decodeExecute.dest <= dest;
		decodeExecute.writesReg <= writesReg;
		decodeExecute.operandA <= readA;
		decodeExecute.operandB <= readB;
		decodeExecute.immediate <= immediate;
		decodeExecute.branchTarget <= fetchDecode.pcPlusOne + immediate;
	end

endmodule

/* source/executeStage.sv */
module executeStage (
	input logic clk,
	input logic reset,
	input cpuPkg::decodeExecuteT decodeExecute,
	input cpuPkg::regWriteT memForward,
	input cpuPkg::regWriteT wbForward,
	output logic branchTaken,
	output cpuPkg::dataT branchTarget,
	output cpuPkg::executeMemoryT executeMemory
);
	import cpuPkg::*;

	dataT operandA;
	dataT operandB;
	dataT aluB;
	dataT aluResult;
	logic useRegB;

	// Nearest producer wins, register read is the fallback
	function automatic dataT forwardOperand(
		regIndexT idx,
		dataT readValue,
		regWriteT memFwd,
		regWriteT wbFwd
	);
		if (memFwd.valid && memFwd.dest == idx) begin
			return memFwd.data;
		end
		if (wbFwd.valid && wbFwd.dest == idx) begin
			return wbFwd.data;
		end
		return readValue;
	endfunction

	assign operandA = forwardOperand(decodeExecute.rs, decodeExecute.operandA,
		memForward, wbForward);
	assign operandB = forwardOperand(decodeExecute.rt, decodeExecute.operandB,
		memForward, wbForward);

	// Immediate forms take B from the immediate
	assign useRegB = decodeExecute.opcode == opR || decodeExecute.opcode == opBne;
	assign aluB = useRegB ? operandB : decodeExecute.immediate;

	always_comb begin
		case (decodeExecute.aluOp)
			aluAdd: aluResult = operandA + aluB;
			aluSub: aluResult = operandA - aluB;
			aluSlt: aluResult = {31'b0, $signed(operandA) < $signed(aluB)};
			aluXor: aluResult = operandA ^ aluB;
			aluPassB: aluResult = aluB;
			default: aluResult = '0;
		endcase
	end

	assign branchTaken = decodeExecute.valid && decodeExecute.opcode == opBne
		&& operandA != operandB;
	assign branchTarget = decodeExecute.branchTarget;

	always_ff @(posedge clk) begin
		if (reset) begin
			executeMemory.valid <= 1'b0;
		end else begin
			executeMemory.valid <= decodeExecute.valid;
		end
		executeMemory.isLoad <= decodeExecute.opcode == opLw;
		executeMemory.isStore <= decodeExecute.opcode == opSw;
		executeMemory.writesReg <= decodeExecute.writesReg;
		executeMemory.dest <= decodeExecute.dest;
		executeMemory.result <= aluResult;
		// SW stores the forwarded rt value
		executeMemory.storeData <= operandB;
	end

endmodule

/* source/memoryWritebackStage.sv */
module memoryWritebackStage #(
	parameter int dataAddrWidth = 10
) (
	input logic clk,
	input logic reset,
	input cpuPkg::executeMemoryT executeMemory,
	output logic [dataAddrWidth-1:0] dataAddr,
	output logic dataWrite,
	output cpuPkg::dataT writeData,
	input cpuPkg::dataT readData,
	output cpuPkg::regWriteT memForward,
	output cpuPkg::regWriteT wbForward
);
	import cpuPkg::*;

	logic writesNonZero;

	assign dataAddr = executeMemory.result[dataAddrWidth-1:0];
	assign writeData = executeMemory.storeData;
	assign dataWrite = executeMemory.valid && executeMemory.isStore;

	assign writesNonZero = executeMemory.writesReg && executeMemory.dest != '0;

	// Load data is already here, so loads forward like ALU results
	assign memForward.valid = executeMemory.valid && writesNonZero;
	assign memForward.dest = executeMemory.dest;
	assign memForward.data = executeMemory.isLoad ? readData : executeMemory.result;

	always_ff @(posedge clk) begin
		if (reset) begin
			wbForward.valid <= 1'b0;
		end else begin
			wbForward.valid <= memForward.valid;
		end
		wbForward.dest <= memForward.dest;
		wbForward.data <= memForward.data;
	end

endmodule

/* source/pipelinedCpu.sv */
module pipelinedCpu #(
	parameter int instrAddrWidth = 10,
	parameter int dataAddrWidth = 10
) (
	input logic clk,
	input logic reset,
	output logic [instrAddrWidth-1:0] instrAddr,
	input cpuPkg::dataT instr,
	output logic [dataAddrWidth-1:0] dataAddr,
	output logic dataWrite,
	output cpuPkg::dataT writeData,
	input cpuPkg::dataT readData,
	output cpuPkg::regWriteT retire
);
	import cpuPkg::*;

	fetchDecodeT fetchDecode;
	decodeExecuteT decodeExecute;
	executeMemoryT executeMemory;
	regWriteT memForward;
	regWriteT wbForward;
	logic branchTaken;
	dataT branchTarget;
	logic jumpTaken;
	dataT jumpTarget;

	// Writeback value is the architectural retire
	assign retire = wbForward;

	fetchStage #(
		.instrAddrWidth(instrAddrWidth)
	) fetchStage_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrAddr(instrAddr),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.jumpTaken(jumpTaken),
		.jumpTarget(jumpTarget),
		.fetchDecode(fetchDecode)
	);

	decodeStage decodeStage_inst (
		.clk(clk),
		.reset(reset),
		.fetchDecode(fetchDecode),
		.regWrite(wbForward),
		.branchTaken(branchTaken),
		.jumpTaken(jumpTaken),
		.jumpTarget(jumpTarget),
		.decodeExecute(decodeExecute)
	);

	executeStage executeStage_inst (
		.clk(clk),
		.reset(reset),
		.decodeExecute(decodeExecute),
		.memForward(memForward),
		.wbForward(wbForward),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.executeMemory(executeMemory)
	);

	memoryWritebackStage #(
		.dataAddrWidth(dataAddrWidth)
	) memoryWritebackStage_inst (
		.clk(clk),
		.reset(reset),
		.executeMemory(executeMemory),
		.dataAddr(dataAddr),
		.dataWrite(dataWrite),
		.writeData(writeData),
		.readData(readData),
		.memForward(memForward),
		.wbForward(wbForward)
	);

endmodule

/* tests/pipelinedCpu_checker.sv */
module pipelinedCpu_checker #(
	parameter int instrAddrWidth = 10
) (
	input logic clk,
	input logic reset,
	input logic [instrAddrWidth-1:0] instrAddr,
	input logic dataWrite,
	input cpuPkg::regWriteT retire,
	input logic branchTaken,
	input cpuPkg::dataT branchTarget,
	input logic jumpTaken,
	input cpuPkg::dataT jumpTarget
);
	int failCount = 0;
	logic [instrAddrWidth-1:0] allowedNext;

	// Branch in execute wins over a jump in decode
	always_comb begin
		if (branchTaken) begin
			allowedNext = branchTarget[instrAddrWidth-1:0];
		end else if (jumpTaken) begin
			allowedNext = jumpTarget[instrAddrWidth-1:0];
		end else begin
			allowedNext = instrAddr + 1'b1;
		end
	end

	resetState: assert property (@(posedge clk)
		reset |=> !retire.valid && !dataWrite && instrAddr == '0)
		else begin
			failCount++;
			$error("pipeline state not cleared by reset");
		end

	// First store can reach memory four edges after release
	quietStore: assert property (@(posedge clk) $fell(reset) |-> !dataWrite [*3])
		else begin
			failCount++;
			$error("store issued before the pipeline filled");
		end

	quietRetire: assert property (@(posedge clk) $fell(reset) |-> !retire.valid [*4])
		else begin
			failCount++;
			$error("retire before the pipeline filled");
		end

	noZeroRetire: assert property (@(posedge clk) disable iff (reset)
		retire.valid |-> retire.dest != '0)
		else begin
			failCount++;
			$error("retire names register zero");
		end

	pcSequence: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> instrAddr == $past(allowedNext))
		else begin
			failCount++;
			$error("fetch address neither stepped nor followed a redirect");
		end

endmodule

bind pipelinedCpu pipelinedCpu_checker #(
	.instrAddrWidth(instrAddrWidth)
) pipelinedCpu_checker_inst (
	.clk(clk),
	.reset(reset),
	.instrAddr(instrAddr),
	.dataWrite(dataWrite),
	.retire(retire),
	.branchTaken(branchTaken),
	.branchTarget(branchTarget),
	.jumpTaken(jumpTaken),
	.jumpTarget(jumpTarget)
);

/* tests/pipelinedCpuTb.sv */
module pipelinedCpuTb;
	import cpuPkg::*;

	localparam int clkPeriod = 20;
	localparam int resetCycles = 10;
	localparam int randomCount = 48;
	localparam int programLength = 8 + randomCount + 13;
	localparam regIndexT markerReg = 5'd8;

	typedef struct packed {
		logic [9:0] addr;
		dataT data;
	} storeT;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [9:0] instrAddr;
	dataT instr;
	logic [9:0] dataAddr;
	logic dataWrite;
	dataT writeData;
	dataT readData;
	regWriteT retire;
	dataT instrMem [1024];
	dataT dataMem [1024];
	dataT modelData [1024];
	logic [31:0] lfsr = 32'h2972c9a8;
	regWriteT expWrites [$];
	storeT expStores [$];

	pipelinedCpu #(
		.instrAddrWidth(10),
		.dataAddrWidth(10)
	) pipelinedCpu_inst (
		.clk(clk),
		.reset(reset),
		.instrAddr(instrAddr),
		.instr(instr),
		.dataAddr(dataAddr),
		.dataWrite(dataWrite),
		.writeData(writeData),
		.readData(readData),
		.retire(retire)
	);

	always #(clkPeriod / 2) clk = ~clk;

	assign instr = instrMem[instrAddr];
	assign readData = dataMem[dataAddr];

	always @(posedge clk) begin
		if (dataWrite) begin
			dataMem[dataAddr] <= writeData;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] randomBits(int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic dataT fillWord(int addr);
		return (32'(addr) * 32'h9e3779b9) ^ 32'h5bd1e995;
	endfunction

	function automatic dataT encI(opcodeT op, regIndexT rs, regIndexT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic dataT encR(funcT func, regIndexT rs, regIndexT rt, regIndexT rd);
		return {opR, rs, rt, rd, 5'd0, func};
	endfunction

	function automatic void buildProgram();
		int pc;
		int kind;
		regIndexT rs;
		regIndexT rt;
		regIndexT rd;
		logic [15:0] imm;
		pc = 0;
		// Opening store gives the earliest possible dataWrite
		instrMem[pc] = encI(opSw, 5'd0, 5'd0, 16'h0010);
		pc++;
		for (int r = 1; r < 8; r++) begin
			imm = 16'(randomBits(16));
			instrMem[pc] = encI(opLi, 5'd0, regIndexT'(r), imm);
			pc++;
		end
		// Eight registers keep dependencies close together
		for (int n = 0; n < randomCount; n++) begin
			kind = int'(randomBits(3));
			rs = regIndexT'(randomBits(3));
			rt = regIndexT'(randomBits(3));
			rd = regIndexT'(randomBits(3));
			imm = 16'(randomBits(16));
			case (kind)
				0: instrMem[pc] = encR(funcAdd, rs, rt, rd);
				1: instrMem[pc] = encR(funcSub, rs, rt, rd);
				2: instrMem[pc] = encR(funcSlt, rs, rt, rd);
				3: instrMem[pc] = encI(opXori, rs, rt, imm);
				4: instrMem[pc] = encI(opLi, rs, rt, imm);
				5, 6: instrMem[pc] = encI(opLw, rs, rt, imm);
				default: instrMem[pc] = encI(opSw, rs, rt, imm);
			endcase
			pc++;
		end
		instrMem[pc] = encI(opLi, 5'd0, 5'd1, 16'd5);
		instrMem[pc + 1] = encI(opLi, 5'd0, 5'd2, 16'd6);
		// Taken BNE skips two marker writes
		instrMem[pc + 2] = encI(opBne, 5'd1, 5'd2, 16'd2);
		instrMem[pc + 3] = encI(opLi, 5'd0, markerReg, 16'h7777);
		instrMem[pc + 4] = encI(opLi, 5'd0, markerReg, 16'h7777);
		instrMem[pc + 5] = encI(opBne, 5'd1, 5'd1, 16'd4);
		instrMem[pc + 6] = encI(opLw, 5'd0, 5'd5, 16'd3);
		instrMem[pc + 7] = encR(funcAdd, 5'd5, 5'd2, 5'd6);
		instrMem[pc + 8] = {opJ, 26'(pc + 10)};
		instrMem[pc + 9] = encI(opLi, 5'd0, markerReg, 16'h7777);
		instrMem[pc + 10] = encR(funcSub, 5'd6, 5'd1, 5'd4);
		instrMem[pc + 11] = {opJ, 26'(pc + 11)};
		instrMem[pc + 12] = encI(opLi, 5'd0, markerReg, 16'h7777);
	endfunction

	// In-order reference model
	function automatic void runModel();
		dataT regs [32];
		dataT pc;
		dataT ins;
		dataT imm;
		dataT a;
		dataT b;
		dataT value;
		regIndexT dest;
		logic writes;
		regWriteT regWrite;
		storeT storeEntry;
		int steps;
		regs = '{default: '0};
		pc = '0;
		steps = 0;
		while (instrMem[pc[9:0]] != {opJ, pc[25:0]} && steps < 1000) begin
			ins = instrMem[pc[9:0]];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			dest = ins[20:16];
			writes = 1'b1;
			value = '0;
			pc = pc + 32'd1;
			case (opcodeT'(ins[31:26]))
				opR: begin
					dest = ins[15:11];
					case (funcT'(ins[5:0]))
						funcAdd: value = a + b;
						funcSub: value = a - b;
						default: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					endcase
				end
				opXori: value = a ^ imm;
				opLi: value = imm;
				opLw: value = modelData[10'(a + imm)];
				opSw: begin
					writes = 1'b0;
					storeEntry.addr = 10'(a + imm);
					storeEntry.data = b;
					modelData[storeEntry.addr] = b;
					expStores.push_back(storeEntry);
				end
				opBne: begin
					writes = 1'b0;
					if (a != b) begin
						pc = pc + imm;
					end
				end
				default: begin
					writes = 1'b0;
					pc = {pc[31:26], ins[25:0]};
				end
			endcase
			if (writes && dest != '0) begin
				regs[dest] = value;
				regWrite.valid = 1'b1;
				regWrite.dest = dest;
				regWrite.data = value;
				expWrites.push_back(regWrite);
			end
			steps++;
		end
	endfunction

	task automatic flagMismatch(string name, dataT got, dataT expected);
		$display("FAILED time=%0t %s got %h expected %h", $time, name, got, expected);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic stopWithError(string what);
		$display("Error at time %0t: %s", $time, what);
		$display("test failed");
		$fatal(1);
	endtask

	always @(negedge clk) begin : checkOutputs
		regWriteT expWrite;
		storeT expStore;
		if (!reset) begin
			assert (pipelinedCpu_inst.pipelinedCpu_checker_inst.failCount == 0)
				else stopWithError("a bound protocol assertion failed");
			if (retire.valid) begin
				assert (retire.dest != markerReg)
					else stopWithError("an instruction in a cancelled slot retired");
				assert (expWrites.size() > 0)
					else stopWithError("retire seen with no register write left in the model");
				expWrite = expWrites.pop_front();
				assert (retire.dest == expWrite.dest)
					else flagMismatch("retire.dest", 32'(retire.dest), 32'(expWrite.dest));
				assert (retire.data == expWrite.data)
					else flagMismatch("retire.data", retire.data, expWrite.data);
			end
			if (dataWrite) begin
				assert (expStores.size() > 0)
					else stopWithError("store seen with no store left in the model");
				expStore = expStores.pop_front();
				assert (dataAddr == expStore.addr)
					else flagMismatch("dataAddr", 32'(dataAddr), 32'(expStore.addr));
				assert (writeData == expStore.data)
					else flagMismatch("writeData", writeData, expStore.data);
			end
		end
	end

	initial begin
		#((resetCycles + programLength * 4 + 100) * clkPeriod);
		$display("Error: program did not complete within the time limit");
		$display("test failed");
		$fatal(1);
	end

	initial begin
		for (int i = 0; i < 1024; i++) begin
			instrMem[i] = '0;
			dataMem[i] = fillWord(i);
			modelData[i] = fillWord(i);
		end
		buildProgram();
		runModel();
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
		while (expWrites.size() != 0 || expStores.size() != 0) begin
			@(negedge clk);
		end
		// Let the final self jump spin so stray retires show up
		repeat (12) @(negedge clk);
		if (pipelinedCpu_inst.pipelinedCpu_checker_inst.failCount == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1);
		end
	end

endmodule

/* sources.f */
source/cpuPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryWritebackStage.sv
source/pipelinedCpu.sv
tests/pipelinedCpu_checker.sv
tests/pipelinedCpuTb.sv

/* Bender.yml */
package:
  name: pipelined_cpu

sources:
  - source/cpuPkg.sv
  - source/fetchStage.sv
  - source/decodeStage.sv
  - source/executeStage.sv
  - source/memoryWritebackStage.sv
  - source/pipelinedCpu.sv
  - target: test
    files:
      - tests/pipelinedCpu_checker.sv
      - tests/pipelinedCpuTb.sv
